// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_blur
FILELIST ?= gauss_blur.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := common/blur_config.svh
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== common/blur_config.svh ====
`ifndef BLUR_CONFIG_SVH
`define BLUR_CONFIG_SVH

// image geometry in pixels
// width must be a whole number of strips
`define BLUR_IMG_WIDTH 64
`define BLUR_IMG_HEIGHT 12

// pixels blurred in one pass of the kernel
`define BLUR_STRIP_PIX 16

// grayscale depth
`define BLUR_PIX_W 8

// kernel weights sum to 16
`define BLUR_KERNEL_SHIFT 4

`endif

// ==== common/blur_pkg.sv ====
`include "blur_config.svh"

package blur_pkg;

  localparam int NUM_STRIPS = `BLUR_IMG_WIDTH / `BLUR_STRIP_PIX;
  localparam int ROW_BITS = `BLUR_IMG_WIDTH * `BLUR_PIX_W;
  localparam int STRIP_BITS = `BLUR_STRIP_PIX * `BLUR_PIX_W;
  // strip plus one halo pixel on each side
  localparam int WIN_BITS = (`BLUR_STRIP_PIX + 2) * `BLUR_PIX_W;
  localparam int ROW_ADDR_W = $clog2(`BLUR_IMG_HEIGHT);
  localparam int STRIP_IDX_W = (NUM_STRIPS > 1) ? $clog2(NUM_STRIPS) : 1;

  typedef logic [`BLUR_PIX_W-1:0] pixel_t;
  typedef logic [ROW_BITS-1:0] row_t;
  typedef logic [STRIP_BITS-1:0] strip_t;
  typedef logic [WIN_BITS-1:0] window_t;
  typedef logic [ROW_ADDR_W-1:0] row_addr_t;
  typedef logic [STRIP_IDX_W-1:0] strip_idx_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    FETCH,
    BLUR,
    MERGE_RD,
    MERGE_WR,
    NEXT_STRIP,
    DONE
  } ctrl_state_t;

endpackage

// ==== gauss_blur.f ====
+incdir+common
common/blur_pkg.sv
hdl/blur_ctrl.sv
line_buffer/line_buffer.sv
kernel/gauss_3x3.sv
hdl/strip_merge.sv
hdl/blur_top.sv
verif/tb_clk_gen.sv
verif/tb_blur.sv

// ==== hdl/blur_ctrl.sv ====
`timescale 1ns/1ps
`include "blur_config.svh"

module blur_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic                 merge_wr_done,
  output logic                 done,
  output logic                 img_re,
  output blur_pkg::row_addr_t  img_addr,
  output logic                 row_load,
  output logic                 row_zero,
  output blur_pkg::strip_idx_t strip_idx,
  output logic                 row_first,
  output logic                 row_last,
  output logic                 kernel_go,
  output logic                 merge_rd,
  output blur_pkg::row_addr_t  merge_row
);

  localparam int LAST_ROW = `BLUR_IMG_HEIGHT - 1;
  localparam int LAST_STRIP = blur_pkg::NUM_STRIPS - 1;

  blur_pkg::ctrl_state_t state;
  blur_pkg::ctrl_state_t state_nxt;
  blur_pkg::strip_idx_t  strip_cnt;
  blur_pkg::row_addr_t   row_cnt;
  logic [1:0]            seq_cnt;
  // one bit wider, the lookahead may point past the bottom row
  logic [blur_pkg::ROW_ADDR_W:0] fetch_row;
  logic                  fetch_issue;
  logic                  fetch_real;

  always_comb begin
    state_nxt = state;
    case (state)
      blur_pkg::IDLE:
        if (start)
          state_nxt = blur_pkg::LOAD;
      // zero row, row 0, row 1, then one cycle for the last capture
      blur_pkg::LOAD:
        if (seq_cnt == 2'd3)
          state_nxt = blur_pkg::BLUR;
      blur_pkg::BLUR:
        state_nxt = blur_pkg::MERGE_RD;
      blur_pkg::MERGE_RD:
        state_nxt = blur_pkg::MERGE_WR;
      blur_pkg::MERGE_WR:
        if (merge_wr_done)
          state_nxt = row_last ? blur_pkg::NEXT_STRIP : blur_pkg::FETCH;
      blur_pkg::FETCH:
        if (seq_cnt == 2'd1)
          state_nxt = blur_pkg::BLUR;
      blur_pkg::NEXT_STRIP:
        if (strip_cnt != blur_pkg::strip_idx_t'(LAST_STRIP))
          state_nxt = blur_pkg::LOAD;
        else if (start)
          state_nxt = blur_pkg::DONE;
        else
          // request withdrawn mid run, no ack to give
          state_nxt = blur_pkg::IDLE;
      blur_pkg::DONE:
        if (!start)
          state_nxt = blur_pkg::IDLE;
      default:
        state_nxt = blur_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= blur_pkg::IDLE;
      strip_cnt <= '0;
      row_cnt <= '0;
      seq_cnt <= '0;
      done <= 1'b0;
    end else begin
      state <= state_nxt;
      done <= (state_nxt == blur_pkg::DONE);
      if (state != state_nxt)
        seq_cnt <= '0;
      else if (state == blur_pkg::LOAD || state == blur_pkg::FETCH)
        seq_cnt <= seq_cnt + 2'd1;
      // strip counter outside, row counter inside
      if (state == blur_pkg::IDLE)
        strip_cnt <= '0;
      else if (state == blur_pkg::NEXT_STRIP && state_nxt == blur_pkg::LOAD)
        strip_cnt <= strip_cnt + 1'b1;
      if (state == blur_pkg::LOAD)
        row_cnt <= '0;
      else if (state == blur_pkg::FETCH && seq_cnt == 2'd1)
        row_cnt <= row_cnt + 1'b1;
    end
  end

  // lookahead row for the bottom of the window
  always_comb begin
    fetch_row = '0;
    fetch_issue = 1'b0;
    if (state == blur_pkg::LOAD) begin
      fetch_issue = (seq_cnt == 2'd1) || (seq_cnt == 2'd2);
      fetch_row[0] = (seq_cnt == 2'd2);
    end else if (state == blur_pkg::FETCH) begin
      fetch_issue = (seq_cnt == 2'd0);
      fetch_row = {1'b0, row_cnt} + 2'd2;
    end
  end

  // past the bottom edge the buffer is fed a zero row
  assign fetch_real = (fetch_row < `BLUR_IMG_HEIGHT);
  assign img_re = fetch_issue && fetch_real;
  assign img_addr = img_re ? fetch_row[blur_pkg::ROW_ADDR_W-1:0] : '0;
  assign row_load = img_re;
  assign row_zero = (state == blur_pkg::LOAD && seq_cnt == 2'd0) ||
                    (fetch_issue && !fetch_real);

  assign strip_idx = strip_cnt;
  assign row_first = (row_cnt == '0);
  assign row_last = (row_cnt == blur_pkg::row_addr_t'(LAST_ROW));
  assign kernel_go = (state == blur_pkg::BLUR);
  assign merge_rd = (state == blur_pkg::BLUR);
  assign merge_row = row_cnt;

  // ack only answers a request that was still up
  a_done_after_start: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(done) |-> $past(start)
  );

  a_img_addr_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    img_re |-> (img_addr < `BLUR_IMG_HEIGHT)
  );

endmodule

// ==== hdl/blur_top.sv ====
`timescale 1ns/1ps

module blur_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  output logic                done,
  output logic                img_re,
  output blur_pkg::row_addr_t img_addr,
  input  blur_pkg::row_t      img_rdata,
  output logic                blur_re,
  output logic                blur_we,
  output blur_pkg::row_addr_t blur_addr,
  output blur_pkg::row_t      blur_wdata,
  input  blur_pkg::row_t      blur_rdata
);

  logic                 row_load;
  logic                 row_zero;
  blur_pkg::strip_idx_t strip_idx;
  logic                 row_first;
  logic                 row_last;
  logic                 kernel_go;
  logic                 merge_rd;
  blur_pkg::row_addr_t  merge_row;
  logic                 merge_wr_done;
  blur_pkg::window_t    win_top;
  blur_pkg::window_t    win_mid;
  blur_pkg::window_t    win_bot;
  logic                 strip_valid;
  blur_pkg::strip_t     strip_out;

  blur_ctrl u_blur_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .merge_wr_done (merge_wr_done),
    .done          (done),
    .img_re        (img_re),
    .img_addr      (img_addr),
    .row_load      (row_load),
    .row_zero      (row_zero),
    .strip_idx     (strip_idx),
    .row_first     (row_first),
    .row_last      (row_last),
    .kernel_go     (kernel_go),
    .merge_rd      (merge_rd),
    .merge_row     (merge_row)
  );

  line_buffer u_line_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .row_load  (row_load),
    .row_zero  (row_zero),
    .img_rdata (img_rdata),
    .strip_idx (strip_idx),
    .row_first (row_first),
    .row_last  (row_last),
    .win_top   (win_top),
    .win_mid   (win_mid),
    .win_bot   (win_bot)
  );

  gauss_3x3 u_gauss_3x3 (
    .clk         (clk),
    .rst_n       (rst_n),
    .kernel_go   (kernel_go),
    .win_top     (win_top),
    .win_mid     (win_mid),
    .win_bot     (win_bot),
    .strip_valid (strip_valid),
    .strip_out   (strip_out)
  );

  strip_merge u_strip_merge (
    .clk           (clk),
    .rst_n         (rst_n),
    .merge_rd      (merge_rd),
    .merge_row     (merge_row),
    .strip_idx     (strip_idx),
    .strip_valid   (strip_valid),
    .strip_out     (strip_out),
    .blur_rdata    (blur_rdata),
    .blur_re       (blur_re),
    .blur_we       (blur_we),
    .blur_addr     (blur_addr),
    .blur_wdata    (blur_wdata),
    .merge_wr_done (merge_wr_done)
  );

endmodule

// ==== hdl/strip_merge.sv ====
`timescale 1ns/1ps

module strip_merge (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 merge_rd,
  input  blur_pkg::row_addr_t  merge_row,
  input  blur_pkg::strip_idx_t strip_idx,
  input  logic                 strip_valid,
  input  blur_pkg::strip_t     strip_out,
  input  blur_pkg::row_t       blur_rdata,
  output logic                 blur_re,
  output logic                 blur_we,
  output blur_pkg::row_addr_t  blur_addr,
  output blur_pkg::row_t       blur_wdata,
  output logic                 merge_wr_done
);

  localparam int SB = blur_pkg::STRIP_BITS;

  blur_pkg::row_t      held_q;
  blur_pkg::row_t      merged;
  blur_pkg::row_addr_t wr_addr_q;
  logic                rd_pend;
  logic                held_valid;

  assign blur_re = merge_rd;
  // single row address, shared by the read and the write back
  assign blur_addr = blur_we ? wr_addr_q : merge_row;
  assign merge_wr_done = blur_we;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      held_valid <= 1'b0;
      blur_we <= 1'b0;
    end else begin
      rd_pend <= merge_rd;
      if (rd_pend)
        held_valid <= 1'b1;
      else if (strip_valid)
        held_valid <= 1'b0;
      blur_we <= strip_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (merge_rd)
      wr_addr_q <= merge_row;
    if (rd_pend)
      held_q <= blur_rdata;
    if (strip_valid)
      blur_wdata <= merged;
  end

  // new strip in place, lower strips from memory
  // first strip of a pass starts the row from zero above it
  always_comb begin
    for (int k = 0; k < blur_pkg::NUM_STRIPS; k++) begin
      if (k == int'(strip_idx))
        merged[k*SB +: SB] = strip_out;
      else if (k > int'(strip_idx) && strip_idx == '0)
        merged[k*SB +: SB] = '0;
      else
        merged[k*SB +: SB] = held_q[k*SB +: SB];
    end
  end

  // the controller must have the read back before the kernel finishes
  a_we_has_data: assert property (
    @(posedge clk) disable iff (!rst_n)
    blur_we |-> $past(held_valid)
  );

endmodule

// ==== kernel/gauss_3x3.sv ====
`timescale 1ns/1ps
`include "blur_config.svh"

module gauss_3x3 (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              kernel_go,
  input  blur_pkg::window_t win_top,
  input  blur_pkg::window_t win_mid,
  input  blur_pkg::window_t win_bot,
  output logic              strip_valid,
  output blur_pkg::strip_t  strip_out
);

  localparam int PIX_W = `BLUR_PIX_W;
  localparam int LANES = `BLUR_STRIP_PIX;
  // 1-2-1 row sum and full 16 weight sum
  localparam int H_W = PIX_W + 2;
  localparam int S_W = PIX_W + 4;

  logic             stage1_valid;
  blur_pkg::strip_t strip_nxt;

  function automatic logic [H_W-1:0] hsum(input blur_pkg::window_t win, input int lane);
    logic [H_W-1:0] left;
    logic [H_W-1:0] centre;
    logic [H_W-1:0] right;
    left = H_W'(win[lane*PIX_W +: PIX_W]);
    centre = H_W'(win[(lane+1)*PIX_W +: PIX_W]);
    right = H_W'(win[(lane+2)*PIX_W +: PIX_W]);
    return left + (centre << 1) + right;
  endfunction

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    logic [H_W-1:0] h_top_q;
    logic [H_W-1:0] h_mid_q;
    logic [H_W-1:0] h_bot_q;
    logic [S_W-1:0] vsum;

    // stage 1, horizontal weights per row
    always_ff @(posedge clk) begin
      if (kernel_go) begin
        h_top_q <= hsum(win_top, i);
        h_mid_q <= hsum(win_mid, i);
        h_bot_q <= hsum(win_bot, i);
      end
    end

    // stage 2 input, vertical weights
    assign vsum = S_W'(h_top_q) + (S_W'(h_mid_q) << 1) + S_W'(h_bot_q);
    assign strip_nxt[i*PIX_W +: PIX_W] = PIX_W'(vsum >> `BLUR_KERNEL_SHIFT);
  end

  always_ff @(posedge clk) begin
    if (stage1_valid)
      strip_out <= strip_nxt;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage1_valid <= 1'b0;
      strip_valid <= 1'b0;
    end else begin
      stage1_valid <= kernel_go;
      strip_valid <= stage1_valid;
    end
  end

endmodule

// ==== line_buffer/line_buffer.sv ====
`timescale 1ns/1ps
`include "blur_config.svh"

module line_buffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 row_load,
  input  logic                 row_zero,
  input  blur_pkg::row_t       img_rdata,
  input  blur_pkg::strip_idx_t strip_idx,
  input  logic                 row_first,
  input  logic                 row_last,
  output blur_pkg::window_t    win_top,
  output blur_pkg::window_t    win_mid,
  output blur_pkg::window_t    win_bot
);

  localparam int PIX_W = `BLUR_PIX_W;
  localparam int EXT_BITS = blur_pkg::ROW_BITS + 2 * PIX_W;

  blur_pkg::row_t row_top;
  blur_pkg::row_t row_mid;
  blur_pkg::row_t row_bot;
  logic           load_d;
  logic           zero_d;

  // memory data lands one cycle after the read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_d <= 1'b0;
      zero_d <= 1'b0;
    end else begin
      load_d <= row_load;
      zero_d <= row_zero;
    end
  end

  always_ff @(posedge clk) begin
    if (load_d || zero_d) begin
      row_top <= row_mid;
      row_mid <= row_bot;
      row_bot <= load_d ? img_rdata : '0;
    end
  end

  // a zero pixel on both ends of the row gives the left and right
  // halo of the outer strips for free
  function automatic blur_pkg::window_t cut_window(
    input blur_pkg::row_t       row,
    input blur_pkg::strip_idx_t idx
  );
    logic [EXT_BITS-1:0] ext;
    ext = {{PIX_W{1'b0}}, row, {PIX_W{1'b0}}};
    return ext[idx * blur_pkg::STRIP_BITS +: blur_pkg::WIN_BITS];
  endfunction

  // top and bottom image borders
  assign win_top = row_first ? '0 : cut_window(row_top, strip_idx);
  assign win_mid = cut_window(row_mid, strip_idx);
  assign win_bot = row_last ? '0 : cut_window(row_bot, strip_idx);

  a_load_zero_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(row_load && row_zero)
  );

endmodule

// ==== verif/tb_blur.sv ====
`timescale 1ns/1ps
`include "blur_config.svh"

module tb_blur;

  localparam int WIDTH = `BLUR_IMG_WIDTH;
  localparam int HEIGHT = `BLUR_IMG_HEIGHT;
  localparam int PIX_W = `BLUR_PIX_W;
  localparam int STRIPS = `BLUR_IMG_WIDTH / `BLUR_STRIP_PIX;
  localparam int PIX_MAX = (1 << `BLUR_PIX_W) - 1;
  localparam int RUNS = 4;
  // a row needs about six cycles, a strip a few more
  localparam int ROW_CYCLE_BOUND = 24;
  localparam int TIMEOUT_CYCLES = RUNS * STRIPS * HEIGHT * ROW_CYCLE_BOUND + 1000;

  logic                clk;
  logic                rst_n;
  logic                start;
  logic                done;
  logic                img_re;
  blur_pkg::row_addr_t img_addr;
  blur_pkg::row_t      img_rdata = '0;
  logic                blur_re;
  logic                blur_we;
  blur_pkg::row_addr_t blur_addr;
  blur_pkg::row_t      blur_wdata;
  blur_pkg::row_t      blur_rdata = '0;

  logic [PIX_W-1:0]    img_px [HEIGHT][WIDTH];
  blur_pkg::row_t      out_mem [HEIGHT];
  logic                img_pend = 1'b0;
  blur_pkg::row_addr_t img_pend_addr;
  logic                blur_pend = 1'b0;
  blur_pkg::row_addr_t blur_pend_addr;
  int                  wr_cnt;
  int                  run_wr_base;
  int                  cycle_cnt;
  logic                start_q;
  logic                done_q;

  tb_clk_gen u_clk_gen (
    .clk (clk)
  );

  blur_top u_blur_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .done       (done),
    .img_re     (img_re),
    .img_addr   (img_addr),
    .img_rdata  (img_rdata),
    .blur_re    (blur_re),
    .blur_we    (blur_we),
    .blur_addr  (blur_addr),
    .blur_wdata (blur_wdata),
    .blur_rdata (blur_rdata)
  );

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %0d expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  // zero outside the image on all four sides
  function automatic int pix_at(input int y, input int x);
    if (y < 0 || y >= HEIGHT || x < 0 || x >= WIDTH)
      return 0;
    return int'(img_px[y][x]);
  endfunction

  function automatic int ref_pixel(input int y, input int x);
    int sum;
    sum = pix_at(y - 1, x - 1) + 2 * pix_at(y - 1, x) + pix_at(y - 1, x + 1) +
          2 * pix_at(y, x - 1) + 4 * pix_at(y, x) + 2 * pix_at(y, x + 1) +
          pix_at(y + 1, x - 1) + 2 * pix_at(y + 1, x) + pix_at(y + 1, x + 1);
    return (sum >> `BLUR_KERNEL_SHIFT) & PIX_MAX;
  endfunction

  // pixel x sits at bits x*PIX_W upward
  function automatic blur_pkg::row_t pack_row(input int y);
    blur_pkg::row_t r;
    for (int x = 0; x < WIDTH; x++)
      r[x*PIX_W +: PIX_W] = img_px[y][x];
    return r;
  endfunction

  task automatic fill_random_image();
    for (int y = 0; y < HEIGHT; y++)
      for (int x = 0; x < WIDTH; x++)
        img_px[y][x] = PIX_W'($urandom % (PIX_MAX + 1));
  endtask

  task automatic fill_const_image(input int val);
    for (int y = 0; y < HEIGHT; y++)
      for (int x = 0; x < WIDTH; x++)
        img_px[y][x] = PIX_W'(val);
  endtask

  // stale junk the engine has to overwrite
  task automatic scramble_out_mem();
    for (int y = 0; y < HEIGHT; y++)
      for (int w = 0; w < WIDTH * PIX_W / 32; w++)
        out_mem[y][w*32 +: 32] = $urandom;
  endtask

  task automatic check_output(input string tag);
    for (int y = 0; y < HEIGHT; y++)
      for (int x = 0; x < WIDTH; x++)
        check_eq(32'(out_mem[y][x*PIX_W +: PIX_W]), 32'(ref_pixel(y, x)),
                 $sformatf("%s row %0d pixel %0d", tag, y, x));
  endtask

  // strips go left to right, rows top to bottom within a strip
  // strips right of the current one stay zero until written
  task automatic check_write(input int n);
    int s;
    int y;
    int exp;
    s = n / HEIGHT;
    y = n % HEIGHT;
    check_eq(32'(blur_addr), 32'(y), "write row address");
    for (int x = 0; x < WIDTH; x++) begin
      exp = (x / `BLUR_STRIP_PIX <= s) ? ref_pixel(y, x) : 0;
      check_eq(32'(blur_wdata[x*PIX_W +: PIX_W]), 32'(exp),
               $sformatf("write %0d pixel %0d", n, x));
    end
  endtask

  // full-white image, corners keep 9 of 16, edges 12 of 16
  task automatic check_border();
    bit edge_y;
    bit edge_x;
    int exp;
    for (int y = 0; y < HEIGHT; y++) begin
      for (int x = 0; x < WIDTH; x++) begin
        edge_y = (y == 0) || (y == HEIGHT - 1);
        edge_x = (x == 0) || (x == WIDTH - 1);
        if (edge_y && edge_x)
          exp = 143;
        else if (edge_y || edge_x)
          exp = 191;
        else
          exp = 255;
        check_eq(32'(out_mem[y][x*PIX_W +: PIX_W]), 32'(exp),
                 $sformatf("border row %0d pixel %0d", y, x));
      end
    end
  endtask

  // one four-phase request, optionally toggling start early in the run
  task automatic run_once(input bit pulse_start);
    int hold;
    run_wr_base = wr_cnt;
    start = 1'b1;
    if (pulse_start) begin
      repeat (20) @(negedge clk);
      check_eq(32'(done), 32'd0, "done early in run");
      start = 1'b0;
      repeat (3) @(negedge clk);
      start = 1'b1;
    end
    @(negedge clk);
    while (!done)
      @(negedge clk);
    check_eq(32'(wr_cnt - run_wr_base), 32'(STRIPS * HEIGHT), "output writes per run");
    hold = 1 + ($urandom % 6);
    repeat (hold) begin
      @(negedge clk);
      check_eq(32'(done), 32'd1, "done held while start high");
    end
    start = 1'b0;
    @(negedge clk);
    check_eq(32'(done), 32'd0, "done after start falls");
  endtask

  // memory models, read data driven one cycle after the request
  always @(negedge clk) begin
    if (img_pend)
      img_rdata = pack_row(int'(img_pend_addr));
    if (blur_pend)
      blur_rdata = out_mem[blur_pend_addr];
    if (blur_we)
      out_mem[blur_addr] = blur_wdata;
    img_pend = img_re;
    img_pend_addr = img_addr;
    blur_pend = blur_re;
    blur_pend_addr = blur_addr;
  end

  always @(posedge clk)
    start_q <= start;

  // protocol monitor
  always @(negedge clk) begin
    if (rst_n) begin
      if (img_re)
        check_eq(32'(img_addr < HEIGHT), 32'd1, "img_addr in range");
      if (blur_re || blur_we)
        check_eq(32'(blur_addr < HEIGHT), 32'd1, "blur_addr in range");
      if (blur_we) begin
        check_write(wr_cnt - run_wr_base);
        wr_cnt++;
      end
      if (done && !done_q)
        check_eq(32'(start_q), 32'd1, "start high when done rises");
    end
    done_q = done;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  initial begin
    int unsigned seed_ret;
    seed_ret = $urandom(24956);
    start = 1'b0;
    rst_n = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // quiet outputs before any request
    repeat (8) begin
      @(negedge clk);
      check_eq(32'(done), 32'd0, "done idle");
      check_eq(32'(img_re), 32'd0, "img_re idle");
      check_eq(32'(blur_re), 32'd0, "blur_re idle");
      check_eq(32'(blur_we), 32'd0, "blur_we idle");
    end

    fill_random_image();
    scramble_out_mem();
    run_once(1'b0);
    check_output("random");

    fill_const_image(255);
    run_once(1'b0);
    check_output("white");
    check_border();

    // back to back, output memory keeps the previous result
    fill_random_image();
    run_once(1'b1);
    check_output("first of pair");
    fill_random_image();
    run_once(1'b0);
    check_output("second of pair");

    $display("Regression passed");
    $finish;
  end

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk
);

  // 8 ns period
  localparam int HALF_NS = 4;

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

endmodule
